//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - common/icache_pkg.sv
      - common/icache_fill_if.sv
      - icache/icache_tag_store.sv
      - icache/icache_data_store.sv
      - icache/icache_miss_unit.sv
      - icache/icache_fetch_ctrl.sv
      - hdl/icache_top.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/icache_tb.sv

//--- common/icache_fill_if.sv
`default_nettype none

// one completed refill, valid for a single cycle
interface icache_fill_if import icache_pkg::*; #(
    parameter int INDEX_W = 8
) ();

    localparam int TAG_W = $bits(addr_t) - OFFSET_W - INDEX_W;

    logic               fill_valid;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    block_t             fill_data;
    // upper word of the block is the fetched instruction
    logic               fill_hi;
    logic               fill_way;

    modport master (
        output fill_valid, fill_index, fill_tag, fill_data, fill_hi, fill_way
    );

    modport receiver (
        input fill_valid, fill_index, fill_tag, fill_data, fill_hi, fill_way
    );

endinterface

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // ====================
    // widths with a meaning
    // ====================

    // fetch or bus byte address
    typedef logic [31:0] addr_t;

    // one instruction
    typedef logic [31:0] inst_t;

    // one cache block, also one R beat
    typedef logic [63:0] block_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    // ====================
    // constants
    // ====================

    localparam resp_t RESP_OKAY = 2'b00;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    // byte offset bits inside a block of 8 bytes
    localparam int OFFSET_W = 3;

    // ====================
    // state machines
    // ====================

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_ADDR,
        MISS_DATA
    } miss_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_HIT,
        FETCH_MISS
    } fetch_state_e;

endpackage

`default_nettype wire

//--- hdl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  addr_t  pc,
    input  logic   stall,
    input  logic   flush,
    output logic   arvalid,
    output addr_t  araddr,
    input  logic   arready,
    input  logic   rvalid,
    input  block_t rdata,
    input  resp_t  rresp,
    output logic   rready,
    output inst_t  inst,
    output logic   inst_valid,
    output logic   error
);

    logic  lookup;
    logic  hit;
    logic  hit_way;
    logic  victim_way;
    inst_t rd_inst;
    logic  miss_req;
    addr_t miss_addr;
    logic  miss_busy;

    icache_fill_if #(.INDEX_W(INDEX_W)) fill_bus ();

    icache_tag_store #(.INDEX_W(INDEX_W)) tag_store_inst (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .pc         (pc),
        .fill       (fill_bus.receiver),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_store #(.INDEX_W(INDEX_W)) data_store_inst (
        .clk     (clk),
        .lookup  (lookup),
        .pc      (pc),
        .hit_way (hit_way),
        .fill    (fill_bus.receiver),
        .rd_inst (rd_inst)
    );

    icache_miss_unit #(.INDEX_W(INDEX_W)) miss_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr),
        .victim_way (victim_way),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .fill       (fill_bus.master),
        .miss_busy  (miss_busy)
    );

    icache_fetch_ctrl fetch_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .hit        (hit),
        .rd_inst    (rd_inst),
        .miss_busy  (miss_busy),
        .rresp      (rresp),
        .fill       (fill_bus.receiver),
        .lookup     (lookup),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error)
    );

endmodule

`default_nettype wire

//--- icache/icache_data_store.sv
`default_nettype none

module icache_data_store import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic   clk,
    input  logic   lookup,
    input  addr_t  pc,
    input  logic   hit_way,
    icache_fill_if.receiver fill,
    output inst_t  rd_inst
);

    localparam int SETS = 1 << INDEX_W;

    logic [INDEX_W-1:0] pc_index;
    logic               way_q;
    logic               hi_q;
    block_t             rd_sel;

    assign pc_index = pc[OFFSET_W +: INDEX_W];

    // one block array per way, registered read
    for (genvar w = 0; w < 2; w++) begin : g_way
        block_t mem [SETS];
        block_t rd_q;

        always_ff @(posedge clk) begin
            if (fill.fill_valid && (fill.fill_way == 1'(w))) begin
                mem[fill.fill_index] <= fill.fill_data;
            end
            if (lookup) begin
                rd_q <= mem[pc_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            way_q <= hit_way;
            hi_q  <= pc[OFFSET_W-1];
        end
    end

    // word select after the read register
    assign rd_sel  = way_q ? g_way[1].rd_q : g_way[0].rd_q;
    assign rd_inst = hi_q ? rd_sel[63:32] : rd_sel[31:0];

endmodule

`default_nettype wire

//--- icache/icache_fetch_ctrl.sv
`default_nettype none

module icache_fetch_ctrl import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t pc,
    input  logic  stall,
    input  logic  flush,
    input  logic  hit,
    input  inst_t rd_inst,
    input  logic  miss_busy,
    input  resp_t rresp,
    icache_fill_if.receiver fill,
    output logic  lookup,
    output logic  miss_req,
    output addr_t miss_addr,
    output inst_t inst,
    output logic  inst_valid,
    output logic  error
);

    fetch_state_e state;

    // after a flush, wait for the old refill to drain
    assign lookup    = (state == FETCH_IDLE) && !stall && !flush && !miss_busy;
    assign miss_req  = lookup && !hit;
    assign miss_addr = pc;

    // ====================
    // fetch FSM
    // ====================

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state      <= FETCH_IDLE;
            inst       <= NOP_INST;
            inst_valid <= 1'b1;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (lookup) begin
                        state      <= hit ? FETCH_HIT : FETCH_MISS;
                        inst_valid <= 1'b0;
                    end
                end
                FETCH_HIT: begin
                    state      <= FETCH_IDLE;
                    inst       <= rd_inst;
                    inst_valid <= 1'b1;
                end
                FETCH_MISS: begin
                    if (fill.fill_valid) begin
                        state      <= FETCH_IDLE;
                        inst       <= fill.fill_hi ? fill.fill_data[63:32]
                                                   : fill.fill_data[31:0];
                        inst_valid <= 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (fill.fill_valid && rresp != RESP_OKAY) begin
            error <= 1'b1;
        end
    end

    // a pending miss always has a refill under way
    miss_in_flight: assert property (@(posedge clk) disable iff (rst)
        state == FETCH_MISS |-> miss_busy);

endmodule

`default_nettype wire

//--- icache/icache_miss_unit.sv
`default_nettype none

module icache_miss_unit import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   miss_req,
    input  addr_t  miss_addr,
    input  logic   victim_way,
    output logic   arvalid,
    output addr_t  araddr,
    input  logic   arready,
    input  logic   rvalid,
    input  block_t rdata,
    output logic   rready,
    icache_fill_if.master fill,
    output logic   miss_busy
);

    localparam int TAG_W = $bits(addr_t) - OFFSET_W - INDEX_W;

    miss_state_e state;
    miss_state_e state_next;

    logic way_q;
    logic hi_q;

    // ====================
    // AXI read FSM
    // ====================

    always_comb begin
        state_next = state;
        case (state)
            MISS_IDLE: begin
                if (miss_req) begin
                    state_next = MISS_ADDR;
                end
            end
            MISS_ADDR: begin
                if (arready) begin
                    state_next = MISS_DATA;
                end
            end
            MISS_DATA: begin
                // the read always completes, even across a flush
                if (rvalid) begin
                    state_next = MISS_IDLE;
                end
            end
            default: state_next = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MISS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request capture, block aligned address
    always_ff @(posedge clk) begin
        if (state == MISS_IDLE && miss_req) begin
            araddr <= {miss_addr[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};
            way_q  <= victim_way;
            hi_q   <= miss_addr[OFFSET_W-1];
        end
    end

    assign arvalid   = (state == MISS_ADDR);
    assign rready    = (state == MISS_DATA);
    assign miss_busy = (state != MISS_IDLE);

    // ====================
    // refill out
    // ====================

    assign fill.fill_valid = rvalid && rready;
    assign fill.fill_index = araddr[OFFSET_W +: INDEX_W];
    assign fill.fill_tag   = araddr[OFFSET_W + INDEX_W +: TAG_W];
    assign fill.fill_data  = rdata;
    assign fill.fill_hi    = hi_q;
    assign fill.fill_way   = way_q;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

//--- icache/icache_tag_store.sv
`default_nettype none

module icache_tag_store import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   lookup,
    input  addr_t  pc,
    icache_fill_if.receiver fill,
    output logic   hit,
    output logic   hit_way,
    output logic   victim_way
);

    localparam int TAG_W = $bits(addr_t) - OFFSET_W - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    typedef logic [TAG_W-1:0] tag_t;

    tag_t            tag_mem [2][SETS];
    logic [SETS-1:0] valid [2];
    // next way to replace in each set
    logic [SETS-1:0] toggle;

    logic [INDEX_W-1:0] pc_index;
    tag_t               pc_tag;
    logic               hit0;
    logic               hit1;

    assign pc_index = pc[OFFSET_W +: INDEX_W];
    assign pc_tag   = pc[OFFSET_W + INDEX_W +: TAG_W];

    // ====================
    // hit compare
    // ====================

    assign hit0 = valid[0][pc_index] && (tag_mem[0][pc_index] == pc_tag);
    assign hit1 = valid[1][pc_index] && (tag_mem[1][pc_index] == pc_tag);

    assign hit        = lookup && (hit0 || hit1);
    assign hit_way    = !hit0;
    assign victim_way = toggle[pc_index];

    // ====================
    // refill
    // ====================

    always_ff @(posedge clk) begin
        if (fill.fill_valid) begin
            tag_mem[toggle[fill.fill_index]][fill.fill_index] <= fill.fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid[0] <= '0;
            valid[1] <= '0;
            toggle   <= '0;
        end else if (fill.fill_valid) begin
            valid[toggle[fill.fill_index]][fill.fill_index] <= 1'b1;
            // the other way goes next time
            toggle[fill.fill_index] <= ~toggle[fill.fill_index];
        end
    end

    // a block never sits in both ways of a set
    one_way_per_tag: assert property (@(posedge clk) disable iff (rst)
        lookup |-> !(hit0 && hit1));

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`default_nettype none

// AXI read slave, block at address A holds {~A, A}
module axi_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold_ar,
    input  logic        bad_resp,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    output logic        arready,
    output logic        rvalid,
    output logic [63:0] rdata,
    output logic [1:0]  rresp,
    input  logic        rready
);

    integer      seed;
    int          wait_cnt;
    logic        busy;
    logic [31:0] addr_q;

    initial begin
        seed = 72726;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= 2'b00;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (!busy) begin
            // address phase
            if (arvalid && arready) begin
                arready  <= 1'b0;
                addr_q   <= araddr;
                busy     <= 1'b1;
                wait_cnt <= $random(seed) & 3;
            end else if (arvalid && !hold_ar) begin
                if (wait_cnt == 0) begin
                    arready <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end else if (rvalid) begin
            if (rready) begin
                rvalid   <= 1'b0;
                busy     <= 1'b0;
                wait_cnt <= $random(seed) & 3;
            end
        end else if (wait_cnt == 0) begin
            rvalid <= 1'b1;
            rdata  <= {~addr_q, addr_q};
            // SLVERR when asked for
            rresp  <= bad_resp ? 2'b10 : 2'b00;
        end else begin
            wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
`default_nettype none

module icache_tb;

    localparam int          INDEX_W    = 8;
    // all tests together stay well under a few hundred cycles
    localparam int          MAX_CYCLES = 4000;
    // addi x0, x0, 0
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready;
    logic        rvalid;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        rready;
    logic [31:0] inst;
    logic        inst_valid;
    logic        error;

    logic        hold_ar;
    logic        bad_resp;

    // what the current fetch should give
    logic [31:0] exp_inst;
    logic [31:0] exp_addr;
    logic        exp_hit;
    // high while a flushed refill is still outstanding
    logic        cancelled;

    int          cycles;

    icache_top #(.INDEX_W(INDEX_W)) icache_top_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .stall      (stall),
        .flush      (flush),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rready     (rready),
        .inst       (inst),
        .inst_valid (inst_valid),
        .error      (error)
    );

    axi_mem_model mem_model_inst (
        .clk      (clk),
        .rst      (rst),
        .hold_ar  (hold_ar),
        .bad_resp (bad_resp),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rresp    (rresp),
        .rready   (rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: no end of test after %0d cycles", cycles));
        end
    end

    // block address in the low word and its inverse in the high word
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] block_addr;
        block_addr = {addr[31:3], 3'b000};
        if (addr[2]) begin
            return ~block_addr;
        end
        return block_addr;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // stall low for one cycle once the cache is idle
    task automatic issue_fetch(input logic [31:0] addr, input logic will_hit);
        while (!inst_valid || arvalid || rready) begin
            @(posedge clk);
        end
        pc       <= addr;
        exp_inst <= expected_word(addr);
        exp_addr <= {addr[31:3], 3'b000};
        exp_hit  <= will_hit;
        stall    <= 1'b0;
        @(posedge clk);
        stall    <= 1'b1;
    endtask

    task automatic wait_output();
        do begin
            @(posedge clk);
        end while (!inst_valid);
    endtask

    task automatic fetch(input logic [31:0] addr, input logic will_hit);
        issue_fetch(addr, will_hit);
        wait_output();
    endtask

    // ====================
    // checks
    // ====================

    after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !arvalid && !rready && !error && inst_valid && inst == NOP)
        else abort_run($sformatf(
            "Error: after reset arvalid=0x%h rready=0x%h error=0x%h inst_valid=0x%h inst=0x%h",
            $sampled(arvalid), $sampled(rready), $sampled(error),
            $sampled(inst_valid), $sampled(inst)));

    inst_rule: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_valid) |-> inst == exp_inst)
        else abort_run($sformatf("Error: inst=0x%h expected 0x%h",
            $sampled(inst), $sampled(exp_inst)));

    miss_start: assert property (@(posedge clk) disable iff (rst)
        !stall && !exp_hit |=> !inst_valid && arvalid && araddr == exp_addr)
        else abort_run($sformatf(
            "Error: miss arvalid=0x%h araddr=0x%h expected 0x%h inst_valid=0x%h",
            $sampled(arvalid), $sampled(araddr), $sampled(exp_addr),
            $sampled(inst_valid)));

    refill_done: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && !cancelled |=> inst_valid && inst == exp_inst)
        else abort_run($sformatf("Error: refill inst_valid=0x%h inst=0x%h expected 0x%h",
            $sampled(inst_valid), $sampled(inst), $sampled(exp_inst)));

    // fixed latency of two and no bus traffic
    hit_path: assert property (@(posedge clk) disable iff (rst)
        !stall && exp_hit |=> !arvalid && !inst_valid
            ##1 !arvalid && inst_valid && inst == exp_inst)
        else abort_run($sformatf(
            "Error: hit arvalid=0x%h inst_valid=0x%h inst=0x%h expected 0x%h",
            $sampled(arvalid), $sampled(inst_valid), $sampled(inst), $sampled(exp_inst)));

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else abort_run($sformatf("Error: AR hold arvalid=0x%h araddr=0x%h was 0x%h",
            $sampled(arvalid), $sampled(araddr), $past(araddr)));

    addr_wait_low: assert property (@(posedge clk) disable iff (rst)
        arvalid && !cancelled |=> !inst_valid)
        else abort_run($sformatf("Error: inst_valid=0x%h during address phase",
            $sampled(inst_valid)));

    data_wait_low: assert property (@(posedge clk) disable iff (rst)
        rready && !rvalid && !cancelled |=> !inst_valid)
        else abort_run($sformatf("Error: inst_valid=0x%h while waiting for rvalid",
            $sampled(inst_valid)));

    flush_nop: assert property (@(posedge clk) disable iff (rst)
        flush |=> inst_valid && inst == NOP)
        else abort_run($sformatf("Error: flush inst_valid=0x%h inst=0x%h expected 0x%h",
            $sampled(inst_valid), $sampled(inst), NOP));

    error_set: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && rresp != 2'b00 |=> error)
        else abort_run($sformatf("Error: error=0x%h after rresp=0x%h",
            $sampled(error), $past(rresp)));

    error_sticky: assert property (@(posedge clk) disable iff (rst)
        error |=> error)
        else abort_run("error flag dropped without a reset");

    error_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(error) |-> $past(rvalid && rready && rresp != 2'b00))
        else abort_run("error flag rose without a bad read response");

    // ====================
    // stimulus
    // ====================

    initial begin
        rst       = 1'b1;
        pc        = '0;
        stall     = 1'b1;
        flush     = 1'b0;
        hold_ar   = 1'b0;
        bad_resp  = 1'b0;
        exp_inst  = NOP;
        exp_addr  = '0;
        exp_hit   = 1'b0;
        cancelled = 1'b0;
        cycles    = 0;
        apply_reset();

        // cold miss then both words of the block hit
        fetch(32'h0000_0040, 1'b0);
        fetch(32'h0000_0040, 1'b1);
        fetch(32'h0000_0044, 1'b1);

        // three tags in set 0x20 evict way 0
        fetch(32'h0000_1100, 1'b0);
        fetch(32'h0000_2100, 1'b0);
        fetch(32'h0000_3100, 1'b0);
        fetch(32'h0000_2104, 1'b1);
        fetch(32'h0000_1100, 1'b0);

        // arready held low for a while
        hold_ar <= 1'b1;
        issue_fetch(32'h0000_020c, 1'b0);
        repeat (12) @(posedge clk);
        hold_ar <= 1'b0;
        wait_output();

        // flush in the middle of a miss
        issue_fetch(32'h0000_0310, 1'b0);
        while (!arvalid) begin
            @(posedge clk);
        end
        flush     <= 1'b1;
        cancelled <= 1'b1;
        exp_inst  <= NOP;
        @(posedge clk);
        flush <= 1'b0;
        while (!(rvalid && rready)) begin
            @(posedge clk);
        end
        cancelled <= 1'b0;
        fetch(32'h0000_0310, 1'b1);
        fetch(32'h0000_0314, 1'b1);

        // bad response sets a flag that outlives later fetches
        bad_resp <= 1'b1;
        fetch(32'h0000_0418, 1'b0);
        bad_resp <= 1'b0;
        fetch(32'h0000_0040, 1'b1);
        repeat (3) @(posedge clk);
        apply_reset();
        repeat (3) @(posedge clk);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/icache_pkg.sv
common/icache_fill_if.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
icache/icache_miss_unit.sv
icache/icache_fetch_ctrl.sv
hdl/icache_top.sv
sim/axi_mem_model.sv
sim/icache_tb.sv
